//--- periph_bus_consts.svh
// word-addressed 16-bit bus; a timer stride of 4 words matches the 2-bit register index.
`ifndef PERIPH_BUS_CONSTS_SVH
`define PERIPH_BUS_CONSTS_SVH

// bus widths.
`define PB_ADDR_W 24
`define PB_DATA_W 16
`define PB_SEL_W 2

// register index inside one slot.
`define PB_IDX_W 2

// number of timer instances.
`define PB_NUM_TIMERS 4

// address map, in 16-bit words.
`define PB_TIMER_BASE 24'h100010
`define PB_TIMER_STRIDE 4

`define PB_IRQC_BASE 24'h100008
`define PB_IRQC_REGS 2

// timer register indices.
`define PB_TMR_RELOAD 2'd0
`define PB_TMR_CTRL 2'd1
`define PB_TMR_COUNT 2'd2

// interrupt controller register indices.
`define PB_IRQ_PEND 2'd0
`define PB_IRQ_MASK 2'd1

`endif

//--- periph_bus_pkg.sv
// bus and slot types; widths come from the consts header, which must be compiled first.
`include "periph_bus_consts.svh"
`default_nettype none

package periph_bus_pkg;

    // request from the bus master.
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`PB_ADDR_W-1:0]   adr;
        logic [`PB_DATA_W-1:0]   dat;
        logic [`PB_SEL_W-1:0]    sel;
    } bus_req_t;

    // response back to the master.
    typedef struct packed {
        logic [`PB_DATA_W-1:0]   dat;
        logic                    ack;
        logic                    err;
    } bus_rsp_t;

    // decoded request, shared by every slot.
    typedef struct packed {
        logic                    stb;
        logic                    we;
        logic [`PB_IDX_W-1:0]    idx;
        logic [`PB_DATA_W-1:0]   dat;
    } slot_req_t;

    typedef struct packed {
        logic [`PB_DATA_W-1:0]   dat;
        logic                    expire; // one-cycle pulse.
    } slot_rsp_t;

    // one-hot slot selection.
    typedef struct packed {
        logic                        irqc;
        logic [`PB_NUM_TIMERS-1:0]   timer;
    } slot_sel_t;

endpackage

`default_nettype wire

//--- periph_bus_decode.sv
// one transfer at a time; a held stb is taken once and must drop before the next request.
`timescale 1ns/100ps
`include "periph_bus_consts.svh"
`default_nettype none

module periph_bus_decode (
    input  wire                          i_clk,
    input  wire                          d_rst,
    input  periph_bus_pkg::bus_req_t     i_req,
    output periph_bus_pkg::slot_req_t    o_slot_req,
    output periph_bus_pkg::slot_sel_t    o_sel,
    output logic                         o_unmapped
);
    import periph_bus_pkg::*;

    localparam logic [`PB_ADDR_W-1:0] tmr_end =
        `PB_ADDR_W'(`PB_TIMER_BASE + `PB_NUM_TIMERS * `PB_TIMER_STRIDE);
    localparam logic [`PB_ADDR_W-1:0] irq_end = `PB_ADDR_W'(`PB_IRQC_BASE + `PB_IRQC_REGS);

    logic                    open_q;
    logic                    accept;
    logic                    tmr_hit;
    logic                    irq_hit;
    logic [`PB_ADDR_W-1:0]   tmr_off;
    logic [`PB_ADDR_W-1:0]   irq_off;
    slot_sel_t               sel_d;
    logic [`PB_IDX_W-1:0]    idx_d;

    logic                    stb_q;
    logic                    we_q;
    logic [`PB_IDX_W-1:0]    idx_q;
    logic [`PB_DATA_W-1:0]   dat_q;

    assign accept  = i_req.cyc & i_req.stb & ~open_q; // first cycle of a request only.
    assign tmr_off = i_req.adr - `PB_TIMER_BASE;
    assign irq_off = i_req.adr - `PB_IRQC_BASE;
    assign tmr_hit = (i_req.adr >= `PB_TIMER_BASE) && (i_req.adr < tmr_end);
    assign irq_hit = (i_req.adr >= `PB_IRQC_BASE) && (i_req.adr < irq_end);

    always_comb begin
        sel_d      = '0;
        sel_d.irqc = irq_hit;
        for (int t = 0; t < `PB_NUM_TIMERS; t++) begin
            if (tmr_hit && (tmr_off[`PB_ADDR_W-1:`PB_IDX_W] == (`PB_ADDR_W-`PB_IDX_W)'(t))) begin
                sel_d.timer[t] = 1'b1;
            end
        end
        idx_d = tmr_hit ? tmr_off[`PB_IDX_W-1:0] : irq_off[`PB_IDX_W-1:0];
    end

    always_ff @(posedge i_clk) begin
        if (d_rst) begin
            open_q     <= 1'b0;
            stb_q      <= 1'b0;
            o_sel      <= '0;
            o_unmapped <= 1'b0;
        end else begin
            open_q     <= i_req.cyc & i_req.stb; // cleared once the master drops stb.
            stb_q      <= accept;
            o_sel      <= accept ? sel_d : '0;
            o_unmapped <= accept & ~(tmr_hit | irq_hit);
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            we_q  <= i_req.we;
            idx_q <= idx_d;
            dat_q <= i_req.dat;
        end
    end

    assign o_slot_req = '{stb: stb_q, we: we_q, idx: idx_q, dat: dat_q};

endmodule

`default_nettype wire

//--- periph_timer.sv
// counts one per clock while enabled; enabling with count 0 leaves the timer idle.
`timescale 1ns/100ps
`include "periph_bus_consts.svh"
`default_nettype none

module periph_timer (
    input  wire                          i_clk,
    input  wire                          d_rst,
    input  periph_bus_pkg::slot_req_t    i_req,
    input  wire                          i_sel,
    output periph_bus_pkg::slot_rsp_t    o_rsp
);

    logic                    wr;
    logic                    acc;
    logic [`PB_DATA_W-1:0]   reload_q;
    logic [`PB_DATA_W-1:0]   count_q;
    logic                    en_q;
    logic                    auto_q;
    logic                    expire_q;
    logic [`PB_DATA_W-1:0]   rd_d;
    logic [`PB_DATA_W-1:0]   rd_q;

    assign acc = i_sel & i_req.stb;
    assign wr  = acc & i_req.we;

    always_ff @(posedge i_clk) begin
        if (d_rst) begin
            reload_q <= '0;
            count_q  <= '0;
            en_q     <= 1'b0;
            auto_q   <= 1'b0;
            expire_q <= 1'b0;
        end else begin
            expire_q <= 1'b0;

            if (en_q && (count_q != '0)) begin
                if (count_q == `PB_DATA_W'(1)) begin
                    expire_q <= 1'b1;
                    if (auto_q) begin
                        count_q <= reload_q;
                    end else begin
                        count_q <= '0;
                        en_q    <= 1'b0; // one-shot stops here.
                    end
                end else begin
                    count_q <= count_q - `PB_DATA_W'(1);
                end
            end

            // bus writes win over the counter.
            if (wr) begin
                case (i_req.idx)
                    `PB_TMR_RELOAD: begin
                        reload_q <= i_req.dat;
                        count_q  <= i_req.dat;
                    end
                    `PB_TMR_CTRL: begin
                        en_q   <= i_req.dat[0];
                        auto_q <= i_req.dat[1];
                    end
                    default: ; // count is read only.
                endcase
            end
        end
    end

    always_comb begin
        case (i_req.idx)
            `PB_TMR_RELOAD: rd_d = reload_q;
            `PB_TMR_CTRL:   rd_d = {{(`PB_DATA_W-2){1'b0}}, auto_q, en_q};
            `PB_TMR_COUNT:  rd_d = count_q;
            default:        rd_d = '0;
        endcase
    end

    // captured with the strobe so it lines up with the drain's ack.
    always_ff @(posedge i_clk) begin
        if (acc) begin
            rd_q <= rd_d;
        end
    end

    assign o_rsp = '{dat: rd_q, expire: expire_q};

endmodule

`default_nettype wire

//--- periph_bus_drain.sv
// pending bits set on expire and win over a clear in the same cycle; dat is 0 outside ack.
`timescale 1ns/100ps
`include "periph_bus_consts.svh"
`default_nettype none

module periph_bus_drain (
    input  wire                                               i_clk,
    input  wire                                               d_rst,
    input  periph_bus_pkg::slot_rsp_t [`PB_NUM_TIMERS-1:0]    i_timer_rsp,
    input  periph_bus_pkg::slot_req_t                         i_slot_req,
    input  periph_bus_pkg::slot_sel_t                         i_sel,
    input  wire                                               i_unmapped,
    output periph_bus_pkg::bus_rsp_t                          o_rsp,
    output logic                                              o_irq
);
    import periph_bus_pkg::*;

    logic [`PB_NUM_TIMERS-1:0]   pend_q;
    logic [`PB_NUM_TIMERS-1:0]   mask_q;
    logic [`PB_NUM_TIMERS-1:0]   expire;
    logic [`PB_NUM_TIMERS-1:0]   clr;
    logic                        irq_acc;
    logic                        irq_wr;
    logic [`PB_DATA_W-1:0]       irq_rd_d;
    logic [`PB_DATA_W-1:0]       irq_rd_q;
    slot_sel_t                   rd_sel_q;
    logic                        ack_q;
    logic                        err_q;
    logic [`PB_DATA_W-1:0]       dat_mux;

    assign irq_acc = i_slot_req.stb & i_sel.irqc;
    assign irq_wr  = irq_acc & i_slot_req.we;
    assign clr     = (irq_wr && (i_slot_req.idx == `PB_IRQ_PEND)) ?
                     i_slot_req.dat[`PB_NUM_TIMERS-1:0] : '0; // write 1 to clear.

    always_comb begin
        for (int t = 0; t < `PB_NUM_TIMERS; t++) begin
            expire[t] = i_timer_rsp[t].expire;
        end
    end

    always_ff @(posedge i_clk) begin
        if (d_rst) begin
            pend_q   <= '0;
            mask_q   <= '0;
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            rd_sel_q <= '0;
        end else begin
            pend_q   <= (pend_q & ~clr) | expire;
            if (irq_wr && (i_slot_req.idx == `PB_IRQ_MASK)) begin
                mask_q <= i_slot_req.dat[`PB_NUM_TIMERS-1:0];
            end
            ack_q    <= i_slot_req.stb & ~i_unmapped;
            err_q    <= i_slot_req.stb & i_unmapped;
            rd_sel_q <= i_slot_req.stb ? i_sel : '0;
        end
    end

    always_comb begin
        case (i_slot_req.idx)
            `PB_IRQ_PEND: irq_rd_d = `PB_DATA_W'(pend_q);
            `PB_IRQ_MASK: irq_rd_d = `PB_DATA_W'(mask_q);
            default:      irq_rd_d = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (irq_acc) begin
            irq_rd_q <= irq_rd_d;
        end
    end

    // timers hold their own registered read data.
    always_comb begin
        dat_mux = '0;
        if (rd_sel_q.irqc) begin
            dat_mux = irq_rd_q;
        end
        for (int t = 0; t < `PB_NUM_TIMERS; t++) begin
            if (rd_sel_q.timer[t]) begin
                dat_mux = i_timer_rsp[t].dat;
            end
        end
    end

    assign o_rsp = '{dat: dat_mux, ack: ack_q, err: err_q};
    assign o_irq = |(pend_q & mask_q);

endmodule

`default_nettype wire

//--- periph_bus_top.sv
// response arrives 2 cycles after the request is first sampled; one transfer in flight.
`timescale 1ns/100ps
`include "periph_bus_consts.svh"
`default_nettype none

module periph_bus_top (
    input  wire                          i_clk,
    input  wire                          d_rst,
    input  periph_bus_pkg::bus_req_t     i_req,
    output periph_bus_pkg::bus_rsp_t     o_rsp,
    output logic                         o_irq
);
    import periph_bus_pkg::*;

    slot_req_t                           slot_req;
    slot_sel_t                           sel;
    logic                                unmapped;
    slot_rsp_t [`PB_NUM_TIMERS-1:0]      timer_rsp;

    periph_bus_decode periph_bus_decode_inst (
        .i_clk      (i_clk),
        .d_rst      (d_rst),
        .i_req      (i_req),
        .o_slot_req (slot_req),
        .o_sel      (sel),
        .o_unmapped (unmapped)
    );

    // identical timers, each on its own select bit.
    for (genvar t = 0; t < `PB_NUM_TIMERS; t++) begin : g_timer
        periph_timer periph_timer_inst (
            .i_clk (i_clk),
            .d_rst (d_rst),
            .i_req (slot_req),
            .i_sel (sel.timer[t]),
            .o_rsp (timer_rsp[t])
        );
    end

    periph_bus_drain periph_bus_drain_inst (
        .i_clk       (i_clk),
        .d_rst       (d_rst),
        .i_timer_rsp (timer_rsp),
        .i_slot_req  (slot_req),
        .i_sel       (sel),
        .i_unmapped  (unmapped),
        .o_rsp       (o_rsp),
        .o_irq       (o_irq)
    );

endmodule

`default_nettype wire

//--- periph_bus_properties.sv
// bound into periph_bus_top; assumes the master holds its request until ack or err.
`timescale 1ns/100ps
`default_nettype none

module periph_bus_properties (
    input  wire                          i_clk,
    input  wire                          d_rst,
    input  periph_bus_pkg::bus_req_t     i_req,
    input  periph_bus_pkg::bus_rsp_t     o_rsp,
    input  wire                          o_irq
);

    int unsigned fails = 0; // read by the testbench at the end of the run.

    a_ack_err_excl: assert property (@(posedge i_clk) disable iff (d_rst)
        !(o_rsp.ack && o_rsp.err))
        else begin
            $error("ack and err are high in the same cycle");
            fails++;
        end

    a_ack_single: assert property (@(posedge i_clk) disable iff (d_rst)
        o_rsp.ack |=> !o_rsp.ack)
        else begin
            $error("ack stayed high for two cycles");
            fails++;
        end

    // o_irq must be low in the cycle after any reset edge.
    a_irq_reset: assert property (@(posedge i_clk)
        d_rst |=> !o_irq)
        else begin
            $error("o_irq high while in reset");
            fails++;
        end

    a_rsp_latency: assert property (@(posedge i_clk) disable iff (d_rst)
        (i_req.cyc && i_req.stb && !$past(i_req.cyc && i_req.stb))
            |-> ##2 (o_rsp.ack || o_rsp.err))
        else begin
            $error("accepted request got no response 2 cycles later");
            fails++;
        end

endmodule

bind periph_bus_top periph_bus_properties periph_bus_properties_inst (.*);

`default_nettype wire

//--- periph_bus_tb.sv
// reads periph_bus_patterns.txt from the run directory; a bus or irq timeout ends the run early.
`timescale 1ns/100ps
`include "periph_bus_consts.svh"
`default_nettype none

module periph_bus_tb;
    import periph_bus_pkg::*;

    localparam int rsp_timeout = 20;
    localparam int irq_timeout = 2000;

    logic       clk;
    logic       d_rst;
    bus_req_t   req;
    bus_rsp_t   rsp;
    logic       irq;
    int         checks;
    int         errors;
    logic       timed_out;

    periph_bus_top periph_bus_top_inst (
        .i_clk (clk),
        .d_rst (d_rst),
        .i_req (req),
        .o_rsp (rsp),
        .o_irq (irq)
    );

    always #10 clk = ~clk;

    // one single transfer; request held until ack or err, then dropped for a cycle.
    task automatic transfer(input logic we, input logic [`PB_ADDR_W-1:0] adr,
                            input logic [`PB_DATA_W-1:0] dat, output bus_rsp_t got);
        int cycles;
        cycles = 0;
        @(posedge clk);
        req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 2'b11};
        @(negedge clk);
        while (!(rsp.ack || rsp.err) && cycles < rsp_timeout) begin
            @(negedge clk);
            cycles++;
        end
        got = rsp;
        if (!(rsp.ack || rsp.err)) begin
            $display("no ack or err for the transfer to address %h", adr);
            errors++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        req <= '0;
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!irq && cycles < irq_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq) begin
            $display("o_irq did not rise within %0d cycles", irq_timeout);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_rsp(input bus_rsp_t got, input logic [`PB_DATA_W-1:0] exp,
                             input logic [`PB_ADDR_W-1:0] adr, input logic cmp_dat);
        checks++;
        if (got.ack !== 1'b1 || got.err !== 1'b0) begin
            $display("ERROR o_rsp.ack at %h: got %h expected 1 (err %h)", adr, got.ack, got.err);
            errors++;
        end else if (cmp_dat && got.dat !== exp) begin
            $display("ERROR o_rsp.dat at %h: got %h expected %h", adr, got.dat, exp);
            errors++;
        end
    endtask

    task automatic check_err(input bus_rsp_t got, input logic [`PB_ADDR_W-1:0] adr);
        checks++;
        if (got.err !== 1'b1 || got.ack !== 1'b0) begin
            $display("ERROR o_rsp.err at %h: got %h expected 1 (ack %h)", adr, got.err, got.ack);
            errors++;
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR o_irq: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    initial begin
        int                      fd;
        int                      afails;
        string                   line;
        logic [7:0]              kind;
        logic [`PB_ADDR_W-1:0]   adr;
        logic [`PB_DATA_W-1:0]   dat;
        logic [`PB_DATA_W-1:0]   exp;
        bus_rsp_t                got;

        clk       = 1'b0;
        d_rst     = 1'b1;
        req       = '0;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        repeat (3) @(posedge clk);
        d_rst <= 1'b0;

        fd = $fopen("periph_bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open periph_bus_patterns.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if ($sscanf(line, "%c %h %h %h", kind, adr, dat, exp) != 4) begin
                    $display("malformed pattern line: %s", line);
                    errors++;
                    continue;
                end
                case (kind)
                    "W": begin
                        transfer(1'b1, adr, dat, got);
                        check_rsp(got, exp, adr, 1'b0);
                    end
                    "R": begin
                        transfer(1'b0, adr, '0, got);
                        check_rsp(got, exp, adr, 1'b1);
                    end
                    "E": begin
                        transfer(1'b0, adr, '0, got);
                        check_err(got, adr);
                    end
                    "I": begin
                        wait_irq();
                        if (!timed_out) begin
                            transfer(1'b0, `PB_IRQC_BASE, '0, got); // pending register.
                            check_rsp(got, exp, `PB_IRQC_BASE, 1'b1);
                        end
                    end
                    "Q": begin
                        @(negedge clk);
                        check_irq(irq, exp[0]);
                    end
                    default: begin
                        $display("unknown pattern kind in line: %s", line);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        afails = periph_bus_top_inst.periph_bus_properties_inst.fails;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- periph_bus.f
+incdir+.
periph_bus_pkg.sv
periph_bus_decode.sv
periph_timer.sv
periph_bus_drain.sv
periph_bus_top.sv
periph_bus_properties.sv
periph_bus_tb.sv

//--- periph_bus_patterns.txt
# kind address data expected, all hex; W write, R read, E access expecting err,
# I wait for o_irq then read pending, Q compare o_irq with expected bit 0
R 100012 0000 0000
R 100016 0000 0000
R 10001A 0000 0000
R 10001E 0000 0000
R 100008 0000 0000
R 100009 0000 0000
W 100010 1234 0000
W 100014 00A5 0000
W 100018 5A5A 0000
W 10001C 0FF0 0000
R 100010 0000 1234
R 100012 0000 1234
R 100014 0000 00A5
R 100016 0000 00A5
R 100018 0000 5A5A
R 10001A 0000 5A5A
R 10001C 0000 0FF0
R 10001E 0000 0FF0
E 10000A 0000 0000
E 100020 0000 0000
E 000010 0000 0000
R 100010 0000 1234
R 100009 0000 0000
W 100009 0002 0000
W 100014 0010 0000
W 100015 0001 0000
I 000000 0000 0002
R 100015 0000 0000
R 100016 0000 0000
W 100008 0002 0000
Q 000000 0000 0000
R 100008 0000 0000
W 100018 0003 0000
W 100019 0001 0000
R 100010 0000 1234
R 100008 0000 0004
Q 000000 0000 0000
R 100019 0000 0000
R 10001A 0000 0000
W 100008 0004 0000
W 100009 0008 0000
W 10001C 0100 0000
W 10001D 0003 0000
I 000000 0000 0008
R 10001D 0000 0003
W 10001D 0000 0000
W 100008 0008 0000
R 100008 0000 0000
Q 000000 0000 0000
